// ==== core_memunit.f ====
+incdir+hw
hw/core_memunit_pkg.sv
hw/core_mem_decode.sv
hw/core_pipe_exec_lsu.sv
hw/core_load_result.sv
hw/core_memunit_top.sv
bench/tb_core_memunit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the load/store path testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_core_memunit -f core_memunit.f \
    && ./obj_dir/Vtb_core_memunit | tee /dev/stderr | grep -q "^Regression passed$" \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: no pass message"; exit 1; }

// ==== bench/tb_core_memunit.sv ====
// Testbench for the load/store path.
// Directed tests issue loads and stores into a memory model with random grant
// delay and compare the results with a byte-lane reference model.

`timescale 1ns/10ps

module tb_core_memunit import core_memunit_pkg::*; ();

    localparam int NUM_TESTS    = 24;
    localparam int RESET_CYCLES = 8;
    localparam int OP_TIMEOUT   = 20;  // Cycles allowed per access

    typedef struct packed {
        logic   done;
        logic   wb_valid;
        logic   trap;
        logic   berr;
        xword_t data;
    } outcome_t;

    logic       g_clk = 1'b0;
    logic       g_resetn;
    logic       instr_valid;
    logic       is_load;
    logic       is_store;
    logic [2:0] funct3;
    xword_t     rs1_val;
    xword_t     imm;
    xword_t     rs2_val;
    logic       done;
    logic       wb_valid;
    xword_t     wb_data;
    logic       trap_misaligned;
    logic       bus_error;
    logic       dmem_req;
    logic       dmem_wen;
    maddr_t     dmem_addr;
    mstrb_t     dmem_strb;
    xword_t     dmem_wdata;
    logic       dmem_gnt;
    logic       dmem_err;
    xword_t     dmem_rdata;

    xword_t      mem [64];      // Memory model contents
    xword_t      ref_mem [64];  // Expected contents
    logic [31:0] lfsr_state;
    logic        err_inject;
    int          cyc = 0;
    int          issue_cyc;
    int          done_cyc;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          failed_tests;
    string       cur_test;
    outcome_t    res;

    // Request monitor, updated at the falling edge
    mem_req_t req_snap;
    logic     req_seen = 1'b0;
    logic     req_active = 1'b0;
    logic     granted = 1'b0;
    logic     hold_err = 1'b0;
    logic     reissued = 1'b0;
    logic     wb_seen = 1'b0;
    int       gnt_cyc = 0;

    core_memunit_top dut_i (.*);

    always #10 g_clk = ~g_clk;

    always @(posedge g_clk) cyc <= cyc + 1;

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;  // Taps 32, 22, 2, 1
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    function automatic xword_t fill_value(input int idx);
        logic [31:0] hash;
        hash = 32'(idx) * 32'h9e37_79b9;
        return {hash, ~hash ^ 32'(idx)};
    endfunction

    function automatic xword_t keep_mask(input int nb);
        return (nb >= 8) ? '1 : ((64'd1 << (8 * nb)) - 64'd1);
    endfunction

    function automatic xword_t lane_mask(input mstrb_t strb);
        xword_t v;
        int     i;
        v = '0;
        for (i = 0; i < 8; i++) begin
            if (((strb >> i) & 8'h01) != 8'h00) begin
                v = v | (64'hff << (8 * i));
            end
        end
        return v;
    endfunction

    // Expected load value from a double word
    function automatic xword_t ref_load(input xword_t dw, input int off, input int nb,
                                        input logic sext);
        xword_t val;
        val = (dw >> (8 * off)) & keep_mask(nb);
        if (sext && ((val >> (8 * nb - 1)) & 64'd1) == 64'd1) begin
            val = val | ~keep_mask(nb);
        end
        return val;
    endfunction

    function automatic mem_req_t port_req();
        mem_req_t r;
        r.req   = dmem_req;
        r.wen   = dmem_wen;
        r.addr  = dmem_addr;
        r.strb  = dmem_strb;
        r.wdata = dmem_wdata;
        return r;
    endfunction

    // Memory model, one grant per request after 0 to 3 wait cycles
    initial begin
        logic [1:0] delay_left;
        logic       busy;
        logic [5:0] idx;
        xword_t     wmask;
        int         i;
        lfsr_state = 32'h9c40;
        busy       = 1'b0;
        delay_left = 2'd0;
        dmem_gnt   = 1'b0;
        dmem_err   = 1'b0;
        dmem_rdata = '0;
        for (i = 0; i < 64; i++) begin
            mem[6'(i)] = fill_value(i);
        end
        forever begin
            @(posedge g_clk);
            #1;
            dmem_gnt   = 1'b0;
            dmem_err   = 1'b0;
            dmem_rdata = '0;
            if (g_resetn && dmem_req) begin
                if (!busy) begin
                    busy       = 1'b1;
                    delay_left = 2'(random_bits(2));
                end
                if (delay_left == 2'd0) begin
                    busy       = 1'b0;
                    idx        = dmem_addr[8:3];
                    dmem_gnt   = 1'b1;
                    dmem_err   = err_inject;
                    dmem_rdata = mem[idx];
                    if (dmem_wen && !err_inject) begin
                        wmask    = lane_mask(dmem_strb);
                        mem[idx] = (mem[idx] & ~wmask) | (dmem_wdata & wmask);
                    end
                end else begin
                    delay_left = delay_left - 2'd1;
                end
            end
        end
    end

    always @(negedge g_clk) begin
        if (instr_valid) begin
            req_seen   <= 1'b0;
            req_active <= 1'b0;
            granted    <= 1'b0;
            hold_err   <= 1'b0;
            reissued   <= 1'b0;
            wb_seen    <= 1'b0;
        end else begin
            if (wb_valid) begin
                wb_seen <= 1'b1;
            end
            if (dmem_req) begin
                req_seen   <= 1'b1;
                req_active <= !dmem_gnt;
                if (granted) begin
                    reissued <= 1'b1;
                end
                if (!req_active) begin
                    req_snap <= port_req();
                end else if (port_req() != req_snap) begin
                    hold_err <= 1'b1;  // Request changed before its grant
                end
                if (dmem_gnt) begin
                    granted <= 1'b1;
                    gnt_cyc <= cyc;
                end
            end
        end
    end

    task automatic check(input string what, input xword_t exp, input xword_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, errors - test_errors);
            failed_tests++;
        end
    endtask

    // Issue one instruction and wait for done
    task automatic run_op(input logic load, input logic [2:0] f3, input maddr_t addr,
                          input xword_t data);
        int waited;
        @(posedge g_clk);
        #1;
        instr_valid = 1'b1;
        is_load     = load;
        is_store    = !load;
        funct3      = f3;
        rs1_val     = {32'hdead_beef, addr - 32'd24};  // Upper half drops out of the sum
        imm         = 64'd24;
        rs2_val     = data;
        issue_cyc   = cyc;
        @(posedge g_clk);
        #1;
        instr_valid = 1'b0;
        res         = '0;
        waited      = 0;
        while (!res.done && waited < OP_TIMEOUT) begin
            @(negedge g_clk);
            waited++;
            if (done) begin
                res = '{done: 1'b1, wb_valid: wb_valid, trap: trap_misaligned,
                        berr: bus_error, data: wb_data};
                done_cyc = cyc;
            end
        end
        if (!res.done) begin
            $display("%s: done did not arrive within %0d cycles", cur_test, OP_TIMEOUT);
            errors++;
        end
        @(posedge g_clk);  // Monitor has seen the last falling edge
        #1;
    endtask

    task automatic check_granted();
        check("request seen", 64'd1, 64'(req_seen));
        check("request held", 64'd0, 64'(hold_err));
        check("request reissued", 64'd0, 64'(reissued));
        check("done after grant", 64'd1, 64'(done_cyc - gnt_cyc));
    endtask

    task automatic model_store(input logic [5:0] idx, input int off, input int nb,
                               input xword_t data);
        xword_t lanes;
        lanes        = (data & keep_mask(nb)) << (8 * off);
        ref_mem[idx] = (ref_mem[idx] & ~(keep_mask(nb) << (8 * off))) | lanes;
    endtask

    task automatic test_store_load(input logic [1:0] w, input int off);
        int         nb;
        logic [5:0] idx;
        maddr_t     base;
        xword_t     data;
        mstrb_t     strb;
        nb   = 1 << w;
        idx  = 6'(8 + 8 * int'(w) + off);
        base = maddr_t'({idx, 3'b000});
        data = 64'h8877_6655_4433_2211 ^ {8{8'(16 * int'(w) + off)}};
        strb = mstrb_t'(((16'd1 << nb) - 16'd1) << off);
        begin_test($sformatf("store_load_b%0d_off%0d", nb, off));
        run_op(1'b0, {1'b0, w}, base + maddr_t'(off), data);
        check_granted();
        check("store wen", 64'd1, 64'(req_snap.wen));
        check("store addr", 64'(base), 64'(req_snap.addr));
        check("store strb", 64'(strb), 64'(req_snap.strb));
        check("store wdata", (data & keep_mask(nb)) << (8 * off),
              req_snap.wdata & lane_mask(strb));
        model_store(idx, off, nb, data);
        run_op(1'b1, {1'b1, w}, base + maddr_t'(off), '0);
        check_granted();
        check("load wb_valid", 64'd1, 64'(res.wb_valid));
        check("load data", ref_load(ref_mem[idx], off, nb, 1'b0), res.data);
        run_op(1'b1, 3'b011, base, '0);  // Whole line, other bytes unchanged
        check("full line", ref_mem[idx], res.data);
        end_test();
    endtask

    task automatic test_extension(input logic [1:0] w);
        int         nb;
        int         off;
        logic [5:0] idx;
        maddr_t     addr;
        xword_t     data;
        nb   = 1 << w;
        off  = 8 - nb;
        idx  = 6'(40 + int'(w));
        addr = maddr_t'({idx, 3'b000}) + maddr_t'(off);
        data = 64'hf0e1_d2c3_b4a5_9687;  // Top bit set at every width
        begin_test($sformatf("extension_b%0d", nb));
        run_op(1'b0, {1'b0, w}, addr, data);
        model_store(idx, off, nb, data);
        run_op(1'b1, {1'b0, w}, addr, '0);
        check("sign extended", ref_load(ref_mem[idx], off, nb, 1'b1), res.data);
        run_op(1'b1, {1'b1, w}, addr, '0);
        check("zero extended", ref_load(ref_mem[idx], off, nb, 1'b0), res.data);
        end_test();
    endtask

    task automatic test_misaligned(input logic load, input logic [1:0] w, input int off);
        begin_test($sformatf("misaligned_%s_b%0d_off%0d", load ? "load" : "store",
                             1 << w, off));
        run_op(load, {1'b0, w}, maddr_t'(48 * 8 + off), 64'h1122_3344_5566_7788);
        check("request seen", 64'd0, 64'(req_seen));
        check("trap_misaligned", 64'd1, 64'(res.trap));
        check("trap timing", 64'd2, 64'(done_cyc - issue_cyc));
        check("wb_valid", 64'd0, 64'(wb_seen));
        end_test();
    endtask

    task automatic test_bus_error(input logic load);
        maddr_t base;
        base = maddr_t'(50 * 8);
        begin_test(load ? "bus_error_load" : "bus_error_store");
        err_inject = 1'b1;
        run_op(load, 3'b011, base, 64'h0bad_0bad_0bad_0bad);
        err_inject = 1'b0;
        check_granted();
        check("bus_error", 64'd1, 64'(res.berr));
        check("wb_valid", 64'd0, 64'(wb_seen));
        run_op(1'b1, 3'b011, base, '0);
        check("line unchanged", ref_mem[6'd50], res.data);
        end_test();
    endtask

    initial begin
        int w;
        int off;
        g_resetn     = 1'b0;
        instr_valid  = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;
        funct3       = '0;
        rs1_val      = '0;
        imm          = '0;
        rs2_val      = '0;
        err_inject   = 1'b0;
        errors       = 0;
        tests_run    = 0;
        failed_tests = 0;
        cur_test     = "reset";
        for (w = 0; w < 64; w++) begin
            ref_mem[6'(w)] = fill_value(w);
        end
        repeat (RESET_CYCLES) @(posedge g_clk);
        #1;
        check("outputs in reset", 64'd0,
              64'({dmem_req, done, wb_valid, trap_misaligned, bus_error}));
        g_resetn = 1'b1;
        for (w = 0; w < 4; w++) begin
            for (off = 0; off < 8; off += (1 << w)) begin
                test_store_load(2'(w), off);
            end
        end
        for (w = 0; w < 3; w++) begin
            test_extension(2'(w));
        end
        test_misaligned(1'b1, 2'd1, 1);
        test_misaligned(1'b0, 2'd2, 2);
        test_misaligned(1'b1, 2'd3, 4);
        test_misaligned(1'b0, 2'd3, 1);
        test_bus_error(1'b1);
        test_bus_error(1'b0);
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #((NUM_TESTS * 20 + RESET_CYCLES) * 20);
        $display("Watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== hw/core_memunit_top.sv ====
// Top level of the load/store path.
// Decoder, access unit and result stage between the instruction input and
// the data memory port. The issuer waits for done before the next
// instruction since the input has no back-pressure.

`timescale 1ns/10ps

module core_memunit_top import core_memunit_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,

    input  logic       instr_valid,
    input  logic       is_load,
    input  logic       is_store,
    input  logic [2:0] funct3,
    input  xword_t     rs1_val,
    input  xword_t     imm,
    input  xword_t     rs2_val,

    output logic       done,
    output logic       wb_valid,
    output xword_t     wb_data,
    output logic       trap_misaligned,
    output logic       bus_error,

    output logic       dmem_req,
    output logic       dmem_wen,
    output maddr_t     dmem_addr,
    output mstrb_t     dmem_strb,
    output xword_t     dmem_wdata,
    input  logic       dmem_gnt,
    input  logic       dmem_err,
    input  xword_t     dmem_rdata
);

    mem_op_t  op;
    mem_req_t mreq;
    logic     new_instr;
    logic     ready;
    logic     trap_addr;

    core_mem_decode decode_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instr_valid (instr_valid),
        .is_load     (is_load),
        .is_store    (is_store),
        .funct3      (funct3),
        .rs1_val     (rs1_val),
        .imm         (imm),
        .rs2_val     (rs2_val),
        .ready       (ready),
        .op          (op),
        .new_instr   (new_instr)
    );

    core_pipe_exec_lsu lsu_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .new_instr (new_instr),
        .op        (op),
        .dmem_gnt  (dmem_gnt),
        .ready     (ready),
        .trap_addr (trap_addr),
        .mreq      (mreq)
    );

    core_load_result result_i (
        .g_clk           (g_clk),
        .g_resetn        (g_resetn),
        .ready           (ready),
        .trap_addr       (trap_addr),
        .dmem_gnt        (dmem_gnt),
        .dmem_err        (dmem_err),
        .dmem_rdata      (dmem_rdata),
        .op              (op),
        .done            (done),
        .wb_valid        (wb_valid),
        .wb_data         (wb_data),
        .trap_misaligned (trap_misaligned),
        .bus_error       (bus_error)
    );

    // Request struct onto the memory port pins
    assign dmem_req   = mreq.req;
    assign dmem_wen   = mreq.wen;
    assign dmem_addr  = mreq.addr;
    assign dmem_strb  = mreq.strb;
    assign dmem_wdata = mreq.wdata;

endmodule

// ==== hw/core_load_result.sv ====
// Load result stage.
// Aligns and extends read data from the memory port and registers the
// completion strobes seen by the issuer, one cycle after ready.

`timescale 1ns/10ps

`include "core_memunit_defines.svh"

module core_load_result import core_memunit_pkg::*; (
    input  logic    g_clk,
    input  logic    g_resetn,
    input  logic    ready,        // Op completes this cycle
    input  logic    trap_addr,
    input  logic    dmem_gnt,
    input  logic    dmem_err,
    input  xword_t  dmem_rdata,
    input  mem_op_t op,
    output logic    done,
    output logic    wb_valid,
    output xword_t  wb_data,
    output logic    trap_misaligned,
    output logic    bus_error
);

    logic [5:0] data_shift;
    xword_t     shifted;
    xword_t     ext;

    assign data_shift = {op.addr[`MEM_OFFS_W-1:0], 3'b000};
    assign shifted    = dmem_rdata >> data_shift;  // Move the lane down to bit 0

    // Mask to the access width and extend from its top bit
    always_comb begin
        unique case (op.width)
            MW_BYTE:
                ext = {{(`XLEN-8){op.sext && shifted[7]}}, shifted[7:0]};
            MW_HALF:
                ext = {{(`XLEN-16){op.sext && shifted[15]}}, shifted[15:0]};
            MW_WORD:
                ext = {{(`XLEN-32){op.sext && shifted[31]}}, shifted[31:0]};
            default:
                ext = shifted;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done            <= 1'b0;
            wb_valid        <= 1'b0;
            trap_misaligned <= 1'b0;
            bus_error       <= 1'b0;
        end else begin
            done            <= ready;
            trap_misaligned <= ready && trap_addr;
            bus_error       <= ready && dmem_gnt && dmem_err;
            wb_valid        <= ready && dmem_gnt && !dmem_err && op.load;
        end
    end

    always_ff @(posedge g_clk) begin
        if (ready && op.load) begin
            wb_data <= ext;
        end
    end

    // At most one outcome is reported per instruction
    a_one_outcome: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $onehot0({wb_valid, trap_misaligned, bus_error}));

endmodule

// ==== hw/core_pipe_exec_lsu.sv ====
// Data memory access unit.
// Checks alignment of the held operation, forms byte strobes and positions
// store data, then holds a request on the memory port until it is granted.
// Combinational apart from the flag that blocks a second request.

`timescale 1ns/10ps

`include "core_memunit_defines.svh"

module core_pipe_exec_lsu import core_memunit_pkg::*; (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     new_instr,  // First cycle of a held op
    input  mem_op_t  op,
    input  logic     dmem_gnt,
    output logic     ready,      // Op completes this cycle
    output logic     trap_addr,  // Misaligned access
    output mem_req_t mreq
);

    logic                  finished;     // Request already granted
    logic                  finished_eff;
    logic                  addr_err;
    logic                  req_sent;
    logic [`MEM_OFFS_W-1:0] boff;
    logic [5:0]            data_shift;
    mstrb_t                strb_base;
    mstrb_t                strb;

    assign boff       = op.addr[`MEM_OFFS_W-1:0];
    assign data_shift = {boff, 3'b000};

    // Alignment rules per access width
    always_comb begin
        unique case (op.width)
            MW_DOUBLE: addr_err = |boff;
            MW_WORD:   addr_err = |boff[1:0];
            MW_HALF:   addr_err = boff[0];
            default:   addr_err = 1'b0;
        endcase
    end

    // Lanes covered by the access before offsetting
    always_comb begin
        unique case (op.width)
            MW_BYTE:   strb_base = 8'h01;
            MW_HALF:   strb_base = 8'h03;
            MW_WORD:   strb_base = 8'h0f;
            default:   strb_base = 8'hff;
        endcase
    end

    assign strb = strb_base << boff;

    // A stale flag from the previous op must not block the first cycle
    assign finished_eff = finished && !new_instr;

    assign req_sent = mreq.req && dmem_gnt;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            finished <= 1'b0;
        end else if (req_sent) begin
            finished <= 1'b1;
        end else if (new_instr) begin
            finished <= 1'b0;
        end
    end

    assign trap_addr = op.valid && addr_err;
    assign ready     = req_sent || trap_addr;

    always_comb begin
        mreq       = '0;
        mreq.req   = op.valid && !addr_err && !finished_eff;
        mreq.wen   = op.store;
        mreq.addr  = {op.addr[`MEM_ADDR_W-1:`MEM_OFFS_W], {`MEM_OFFS_W{1'b0}}};
        mreq.strb  = mreq.req ? strb : '0;
        mreq.wdata = op.wdata << data_shift;
    end

    // Memory sees a stable request until its grant
    a_req_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (mreq.req && !dmem_gnt) |=> (mreq.req && $stable(mreq)));

    // Granted request is not raised again
    a_no_reissue: assert property (@(posedge g_clk) disable iff (!g_resetn)
        req_sent |=> !mreq.req);

endmodule

// ==== hw/core_mem_decode.sv ====
// Memory instruction decoder.
// Turns the single-cycle instruction strobe into a held operation for the
// access unit, with effective address, access width and extension mode.
// The operation stays valid until the access unit signals ready.

`timescale 1ns/10ps

`include "core_memunit_defines.svh"

module core_mem_decode import core_memunit_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       instr_valid,  // One cycle per instruction
    input  logic       is_load,
    input  logic       is_store,
    input  logic [2:0] funct3,
    input  xword_t     rs1_val,      // Base register
    input  xword_t     imm,          // Offset
    input  xword_t     rs2_val,      // Store data
    input  logic       ready,        // Access unit finished with op
    output mem_op_t    op,
    output logic       new_instr
);

    mem_op_t dec;       // Operation decoded from the inputs
    mem_op_t op_hold;   // Payload held for the access
    logic    valid_q;

    always_comb begin
        dec       = '0;
        dec.valid = 1'b1;
        dec.load  = is_load;
        dec.store = is_store;
        dec.width = mem_width_t'(funct3[1:0]);
        dec.sext  = !funct3[2];  // Bit 2 selects the unsigned loads
        dec.addr  = rs1_val[`MEM_ADDR_W-1:0] + imm[`MEM_ADDR_W-1:0];
        dec.wdata = rs2_val;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            valid_q   <= 1'b0;
            new_instr <= 1'b0;
        end else begin
            new_instr <= instr_valid;
            if (instr_valid) begin
                valid_q <= 1'b1;
            end else if (ready) begin
                valid_q <= 1'b0;  // Cleared once completed or trapped
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (instr_valid) begin
            op_hold <= dec;
        end
    end

    always_comb begin
        op       = op_hold;
        op.valid = valid_q;
    end

    // Issuer must wait for completion before the next instruction
    a_no_overlap: assert property (@(posedge g_clk) disable iff (!g_resetn)
        instr_valid |-> !op.valid);

endmodule

// ==== hw/core_memunit_pkg.sv ====
// Types shared by the decoder, access unit and result stage.
// Modules pull these in with a wildcard import in their header.

`include "core_memunit_defines.svh"

package core_memunit_pkg;

    typedef logic [`XLEN-1:0]       xword_t;   // Register or data value
    typedef logic [`MEM_ADDR_W-1:0] maddr_t;   // Byte address
    typedef logic [`MEM_STRB_W-1:0] mstrb_t;   // Byte lane strobes

    // Encoding follows funct3[1:0]
    typedef enum logic [1:0] {
        MW_BYTE   = 2'd0,
        MW_HALF   = 2'd1,
        MW_WORD   = 2'd2,
        MW_DOUBLE = 2'd3
    } mem_width_t;

    typedef struct packed {
        logic       valid;
        logic       load;
        logic       store;
        mem_width_t width;
        logic       sext;   // Sign extend load data
        maddr_t     addr;   // Effective byte address
        xword_t     wdata;  // Unshifted store data
    } mem_op_t;

    typedef struct packed {
        logic   req;
        logic   wen;
        maddr_t addr;       // Double word aligned
        mstrb_t strb;
        xword_t wdata;      // Already positioned on its byte lanes
    } mem_req_t;

endpackage

// ==== hw/core_memunit_defines.svh ====
// Width macros shared by the load/store path.
// Include this ahead of the package and in any module that slices by width.

`ifndef CORE_MEMUNIT_DEFINES_SVH
`define CORE_MEMUNIT_DEFINES_SVH

// Register and data path width
`define XLEN        64

// Byte address width on the data memory port
`define MEM_ADDR_W  32

// One strobe per byte of a data word
`define MEM_STRB_W  8

// Byte offset bits within one data word
`define MEM_OFFS_W  3

`endif
